/* bench/if_stage_tests.txt */
// pc_mux exc_pc_mux cause boot target mepc depc mtvec err_addr nwords first_pc
// all hex, nwords is the number of words consumed after the redirect
0 0 00 00001000 00000000 00000000 00000000 00000000 00001088 6 00001080
1 0 00 00001000 00002000 00000000 00000000 00000000 fffffffc 5 00002000
2 0 00 00001000 00000000 00000000 00000000 00003001 00003004 4 00003000
2 1 25 00001000 00000000 00000000 00000000 00004000 fffffffc 4 00004014
2 2 00 00001000 00000000 00000000 00000000 00004000 1a110804 3 1a110800
2 3 00 00001000 00000000 00000000 00000000 00004000 fffffffc 3 1a110808
3 0 00 00001000 00000000 00005104 00000000 00004000 fffffffc 5 00005104
4 0 00 00001000 00000000 00005104 00006200 00004000 00006208 4 00006200
1 0 00 00001000 00007002 00005104 00006200 00004000 fffffffc 4 00007000
0 0 00 0000a0ff 00007002 00005104 00006200 00004000 0000a084 4 0000a080
2 1 3f 0000a0ff 00007002 00005104 00006200 0000b0c0 fffffffc 3 0000b07c
2 1 23 0000a0ff 00007002 00005104 00006200 0000c000 0000c010 3 0000c00c
1 0 00 0000a0ff 00008000 00005104 00006200 0000c000 00008010 8 00008000
3 0 00 0000a0ff 00008000 00009000 00006200 0000c000 fffffffc 2 00009000
2 0 00 0000a0ff 00008000 00009000 00006200 0000d0ff 0000d000 3 0000d000
1 0 00 0000a0ff 0000e000 00009000 00006200 0000d0ff fffffffc 1 0000e000
1 0 00 0000a0ff 0000e100 00009000 00006200 0000d0ff 0000e100 1 0000e100
4 0 00 0000a0ff 0000e100 00009000 0000f004 0000d0ff 0000f008 6 0000f004
0 0 00 00010000 0000e100 00009000 0000f004 0000d0ff fffffffc 3 00010080
1 0 00 00010000 00011000 00009000 0000f004 0000d0ff 00011024 a 00011000

/* if_stage.f */
+incdir+rtl
rtl/if_ctrl_pkg.sv
rtl/if_fetch_pkg.sv
rtl/if_fetch_intf.sv
rtl/if_fetch_addr_mux.sv
rtl/if_fetch_unit.sv
rtl/if_id_pipe.sv
rtl/if_stage.sv
bench/if_stage_asserts.sv
bench/if_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
  --top-module if_stage_tb \
  -Mdir obj_dir \
  -o if_stage_tb \
  -f if_stage.f
./obj_dir/if_stage_tb

/* bench/if_stage_tb.sv */
// testbench for the instruction fetch stage
// bus memory model with random grant delay, redirect tests from a data file

`timescale 1ns/1ns

module if_stage_tb;

  localparam int NumTests  = 20;
  localparam int NumFields = 11;

  logic                     clk_i          = 1'b0;
  logic                     rst_ni         = 1'b0;
  if_fetch_pkg::addr_t      boot_addr_i    = '0;
  logic                     req_i          = 1'b0;
  logic                     instr_req_o;
  if_fetch_pkg::addr_t      instr_addr_o;
  logic                     instr_gnt_i    = 1'b0;
  logic                     instr_rvalid_i = 1'b0;
  if_fetch_pkg::instr_t     instr_rdata_i  = '0;
  logic                     instr_err_i    = 1'b0;
  logic                     instr_valid_id_o;
  logic                     instr_new_id_o;
  if_fetch_pkg::instr_t     instr_rdata_id_o;
  if_fetch_pkg::instr_t     instr_rdata_alu_id_o;
  logic                     instr_fetch_err_o;
  if_fetch_pkg::addr_t      pc_if_o;
  if_fetch_pkg::addr_t      pc_id_o;
  logic                     instr_valid_clear_i = 1'b0;
  logic                     pc_set_i            = 1'b0;
  if_ctrl_pkg::pc_sel_e     pc_mux_i            = if_ctrl_pkg::PC_BOOT;
  if_ctrl_pkg::exc_pc_sel_e exc_pc_mux_i        = if_ctrl_pkg::EXC_PC_EXC;
  if_ctrl_pkg::exc_cause_t  exc_cause_i         = '0;
  if_fetch_pkg::addr_t      branch_target_i     = '0;
  if_fetch_pkg::addr_t      csr_mepc_i          = '0;
  if_fetch_pkg::addr_t      csr_depc_i          = '0;
  if_fetch_pkg::addr_t      csr_mtvec_i         = '0;
  logic                     csr_mtvec_init_o;
  logic                     id_in_ready_i       = 1'b0;
  logic                     if_busy_o;

  // one line per test, fields in file column order
  logic [31:0]         tests [NumTests*NumFields];
  int                  seed = 34;
  int                  cycle_cnt;
  int                  cycle_limit;
  int                  total_words;
  int                  want_words;
  int                  got_words;
  int                  gap;
  if_fetch_pkg::addr_t exp_pc;
  if_fetch_pkg::addr_t err_addr = '1;
  logic                new_seen   = 1'b0;
  logic                clear_seen = 1'b0;
  // buffer address seen at the previous falling edge
  if_fetch_pkg::addr_t pc_if_prev = '0;

  // memory model state, sampled at the rising edge
  logic                gnt_acc_q  = 1'b0;
  logic                mem_err_q  = 1'b0;
  if_fetch_pkg::addr_t mem_addr_q = '0;
  int                  wait_cnt   = 0;
  int                  wait_lim   = 0;

  if_stage i_dut (.*);

  always #4 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // instruction memory
  //////////////////////////////////////////////////////////////////////

  // grant after 0 to 3 request cycles, answer in the cycle after the grant
  always @(posedge clk_i) begin
    gnt_acc_q <= rst_ni & instr_req_o & instr_gnt_i;
    if (!rst_ni) begin
      wait_cnt <= 0;
    end else if (instr_req_o && instr_gnt_i) begin
      mem_addr_q <= instr_addr_o;
      mem_err_q  <= (instr_addr_o == err_addr);
      wait_cnt   <= 0;
      wait_lim   <= $unsigned($random(seed)) % 4;
    end else if (instr_req_o) begin
      wait_cnt <= wait_cnt + 1;
    end
  end

  always @(negedge clk_i) begin
    instr_gnt_i    <= (wait_cnt >= wait_lim);
    instr_rvalid_i <= gnt_acc_q;
    instr_rdata_i  <= mem_addr_q ^ 32'h5A5A0000;
    instr_err_i    <= gnt_acc_q & mem_err_q;
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_addr(input if_fetch_pkg::addr_t got, input if_fetch_pkg::addr_t exp,
                            input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_instr(input if_fetch_pkg::instr_t got, input if_fetch_pkg::instr_t exp,
                             input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  // word at the ID outputs must be the next one of the current stream
  task automatic check_word();
    if_fetch_pkg::instr_t exp_word;
    exp_word = exp_pc ^ 32'h5A5A0000;
    check_addr(pc_id_o, exp_pc, "pc of fetched word");
    // the word sat in the fetch buffer during its transfer cycle
    check_addr(pc_if_prev, exp_pc, "pc of buffered word");
    check_instr(instr_rdata_id_o, exp_word, "decode word");
    check_instr(instr_rdata_alu_id_o, exp_word, "alu copy of word");
    check_bit(instr_fetch_err_o, exp_pc == err_addr, "fetch error flag");
    exp_pc = exp_pc + 32'd4;
    got_words++;
  endtask

  // one clock cycle, consumer side, inputs driven at the falling edge
  task automatic tick(input logic consume);
    @(negedge clk_i);
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: fetched words stopped arriving after %0d cycles", cycle_cnt);
      abort_run();
    end
    // valid holds up to the clear edge and drops after it
    if (new_seen) begin
      check_bit(instr_valid_id_o, 1'b1, "valid dropped before clear");
    end
    if (clear_seen && !instr_new_id_o) begin
      check_bit(instr_valid_id_o, 1'b0, "valid stayed high after clear");
    end
    if (instr_new_id_o) begin
      check_word();
    end
    pc_if_prev          = pc_if_o;
    clear_seen          = new_seen;
    instr_valid_clear_i = new_seen;
    new_seen            = instr_new_id_o;
    pc_set_i            = 1'b0;
    id_in_ready_i       = consume && (($random(seed) & 3) != 0);
  endtask

  // redirect to the source given by test line t
  task automatic redirect(input int t);
    int base;
    base = t * NumFields;
    tick(1'b0);
    pc_mux_i        = if_ctrl_pkg::pc_sel_e'(tests[base][2:0]);
    exc_pc_mux_i    = if_ctrl_pkg::exc_pc_sel_e'(tests[base+1][1:0]);
    exc_cause_i     = if_ctrl_pkg::exc_cause_t'(tests[base+2][5:0]);
    boot_addr_i     = tests[base+3];
    branch_target_i = tests[base+4];
    csr_mepc_i      = tests[base+5];
    csr_depc_i      = tests[base+6];
    csr_mtvec_i     = tests[base+7];
    err_addr        = tests[base+8];
    want_words      = int'(tests[base+9]);
    exp_pc          = tests[base+10];
    got_words       = 0;
    pc_set_i        = 1'b1;
    req_i           = 1'b1;
    @(posedge clk_i);
    check_bit(csr_mtvec_init_o, pc_mux_i == if_ctrl_pkg::PC_BOOT, "mtvec init strobe");
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    $readmemh("bench/if_stage_tests.txt", tests);
    total_words = 0;
    for (int t = 0; t < NumTests; t++) begin
      total_words += int'(tests[t*NumFields+9]);
    end
    cycle_cnt   = 0;
    cycle_limit = 16 + total_words * 12 + NumTests * 10;

    repeat (16) tick(1'b0);
    rst_ni = 1'b1;
    tick(1'b0);
    check_bit(instr_req_o, 1'b0, "bus request after reset");
    check_bit(instr_valid_id_o, 1'b0, "valid after reset");
    check_bit(instr_new_id_o, 1'b0, "new flag after reset");
    check_bit(if_busy_o, 1'b0, "busy after reset");

    for (int t = 0; t < NumTests; t++) begin
      redirect(t);
      while (got_words < want_words) begin
        tick(1'b1);
      end
      // stall so the next redirect often meets a request in flight
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) tick(1'b0);
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* bench/if_stage_asserts.sv */
// bus protocol and select checks for the fetch stage
// bound into the fetch stage top level

`timescale 1ns/1ns

module if_stage_asserts (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     instr_req_o,
  input if_fetch_pkg::addr_t      instr_addr_o,
  input logic                     instr_gnt_i,
  input logic                     instr_rvalid_i,
  input logic                     pc_set_i,
  input if_ctrl_pkg::pc_sel_e     pc_mux_i,
  input if_ctrl_pkg::exc_pc_sel_e exc_pc_mux_i
);

  // granted request still waiting for its answer
  logic gnt_open_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_open_q <= 1'b0;
    end else if (instr_req_o && instr_gnt_i) begin
      gnt_open_q <= 1'b1;
    end else if (instr_rvalid_i) begin
      gnt_open_q <= 1'b0;
    end
  end

  req_addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> !$isunknown(instr_addr_o) && (instr_addr_o[1:0] == 2'b00))
    else $error("request address unknown or not word aligned");

  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("request or address changed before grant");

  rvalid_granted: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_rvalid_i |-> gnt_open_q)
    else $error("rvalid without an outstanding grant");

  sel_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i |-> !$isunknown({pc_mux_i, exc_pc_mux_i}))
    else $error("pc select unknown during redirect");

endmodule

bind if_stage if_stage_asserts i_asserts (.*);

/* rtl/if_stage.sv */
// instruction fetch stage top
// address mux feeds the fetch unit, the fetch unit feeds the IF-ID register

`timescale 1ns/1ns

module if_stage (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  input  if_fetch_pkg::addr_t      boot_addr_i,
  input  logic                     req_i,

  // instruction bus
  output logic                     instr_req_o,
  output if_fetch_pkg::addr_t      instr_addr_o,
  input  logic                     instr_gnt_i,
  input  logic                     instr_rvalid_i,
  input  if_fetch_pkg::instr_t     instr_rdata_i,
  input  logic                     instr_err_i,

  // towards decode
  output logic                     instr_valid_id_o,
  output logic                     instr_new_id_o,
  output if_fetch_pkg::instr_t     instr_rdata_id_o,
  output if_fetch_pkg::instr_t     instr_rdata_alu_id_o,
  output logic                     instr_fetch_err_o,
  output if_fetch_pkg::addr_t      pc_if_o,
  output if_fetch_pkg::addr_t      pc_id_o,

  // control from the core
  input  logic                     instr_valid_clear_i,
  input  logic                     pc_set_i,
  input  if_ctrl_pkg::pc_sel_e     pc_mux_i,
  input  if_ctrl_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  if_ctrl_pkg::exc_cause_t  exc_cause_i,
  input  if_fetch_pkg::addr_t      branch_target_i,

  // csr values
  input  if_fetch_pkg::addr_t      csr_mepc_i,
  input  if_fetch_pkg::addr_t      csr_depc_i,
  input  if_fetch_pkg::addr_t      csr_mtvec_i,
  output logic                     csr_mtvec_init_o,

  input  logic                     id_in_ready_i,
  output logic                     if_busy_o
);

  if_fetch_pkg::addr_t fetch_addr_n;

  // word channel between fetch unit and pipeline register
  if_fetch_intf i_fetch_if ();

  if_fetch_addr_mux i_addr_mux (
    .pc_mux_i        (pc_mux_i),
    .exc_pc_mux_i    (exc_pc_mux_i),
    .exc_cause_i     (exc_cause_i),
    .boot_addr_i     (boot_addr_i),
    .branch_target_i (branch_target_i),
    .csr_mepc_i      (csr_mepc_i),
    .csr_depc_i      (csr_depc_i),
    .csr_mtvec_i     (csr_mtvec_i),
    .fetch_addr_n_o  (fetch_addr_n)
  );

  if_fetch_unit i_fetch_unit (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .pc_set_i       (pc_set_i),
    .fetch_addr_n_i (fetch_addr_n),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .busy_o         (if_busy_o),
    .fetch          (i_fetch_if)
  );

  if_id_pipe i_id_pipe (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .fetch                (i_fetch_if),
    .id_in_ready_i        (id_in_ready_i),
    .pc_set_i             (pc_set_i),
    .instr_valid_clear_i  (instr_valid_clear_i),
    .instr_valid_id_o     (instr_valid_id_o),
    .instr_new_id_o       (instr_new_id_o),
    .instr_rdata_id_o     (instr_rdata_id_o),
    .instr_rdata_alu_id_o (instr_rdata_alu_id_o),
    .instr_fetch_err_o    (instr_fetch_err_o),
    .pc_id_o              (pc_id_o)
  );

  // address of the word waiting in the fetch buffer
  assign pc_if_o = i_fetch_if.fetch_addr;

  // csr file loads mtvec from the boot address on a boot redirect
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == if_ctrl_pkg::PC_BOOT);

endmodule

/* rtl/if_id_pipe.sv */
// IF-ID pipeline register
// captures each accepted word with its pc and error, tracks valid and new

`timescale 1ns/1ns

module if_id_pipe (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // word from the fetch unit
  if_fetch_intf.dst            fetch,

  input  logic                 id_in_ready_i,
  input  logic                 pc_set_i,
  input  logic                 instr_valid_clear_i,

  // towards decode
  output logic                 instr_valid_id_o,
  output logic                 instr_new_id_o,
  output if_fetch_pkg::instr_t instr_rdata_id_o,
  output if_fetch_pkg::instr_t instr_rdata_alu_id_o,
  output logic                 instr_fetch_err_o,
  output if_fetch_pkg::addr_t  pc_id_o
);

  logic valid_d;
  logic new_d;

  // decode readiness is the only back-pressure
  assign fetch.fetch_ready = id_in_ready_i;

  // a word enters the register on every transfer
  assign new_d = fetch.fetch_valid & fetch.fetch_ready;

  // a word arriving with a redirect is squashed
  // valid holds until decode clears it
  assign valid_d = (new_d & ~pc_set_i) | (instr_valid_id_o & ~instr_valid_clear_i);

  ////////////////////////////////////////////////////////////////////
  // flags
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
    end else begin
      instr_valid_id_o <= valid_d;
      // one cycle pulse per accepted word
      instr_new_id_o   <= new_d;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // word, pc and error
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_rdata_id_o     <= '0;
      instr_rdata_alu_id_o <= '0;
      instr_fetch_err_o    <= 1'b0;
      pc_id_o              <= '0;
    end else if (new_d) begin
      instr_rdata_id_o     <= fetch.fetch_rdata;
      // second copy feeds the alu operand path, cuts fan-out
      instr_rdata_alu_id_o <= fetch.fetch_rdata;
      instr_fetch_err_o    <= fetch.fetch_err;
      pc_id_o              <= fetch.fetch_addr;
    end
  end

endmodule

/* rtl/if_fetch_unit.sv */
// instruction bus requester
// one request outstanding at a time, responses land in a one-entry buffer
// responses of a redirected stream are dropped

`timescale 1ns/1ns

`include "if_params.svh"

module if_fetch_unit (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  logic                 req_i,
  input  logic                 pc_set_i,
  input  if_fetch_pkg::addr_t  fetch_addr_n_i,

  // instruction bus
  output logic                 instr_req_o,
  output if_fetch_pkg::addr_t  instr_addr_o,
  input  logic                 instr_gnt_i,
  input  logic                 instr_rvalid_i,
  input  if_fetch_pkg::instr_t instr_rdata_i,
  input  logic                 instr_err_i,

  output logic                 busy_o,

  // buffered word towards the IF-ID register
  if_fetch_intf.src            fetch
);

  // sequential stream address
  if_fetch_pkg::addr_t  fetch_addr_q;
  // request raised but not yet granted
  logic                 hold_q;
  logic                 hold_stale_q;
  if_fetch_pkg::addr_t  hold_addr_q;
  // granted request waiting for rvalid
  logic                 out_q;
  logic                 discard_q;
  if_fetch_pkg::addr_t  rsp_addr_q;
  // one-entry word buffer
  logic                 buf_valid_q;
  if_fetch_pkg::instr_t buf_rdata_q;
  if_fetch_pkg::addr_t  buf_addr_q;
  logic                 buf_err_q;

  logic                 req_new;
  logic                 gnt_acc;
  logic                 rsp_keep;
  logic                 buf_pop;
  if_fetch_pkg::addr_t  redir_addr;

  ////////////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////////////

  // fresh request only with an empty buffer and an idle bus
  assign req_new = req_i & ~pc_set_i & ~buf_valid_q & ~out_q & ~hold_q;

  // an ungranted request stays up, also across a redirect
  assign instr_req_o  = hold_q | req_new;
  assign instr_addr_o = hold_q ? hold_addr_q : fetch_addr_q;
  assign gnt_acc      = instr_req_o & instr_gnt_i;

  assign busy_o = instr_req_o | out_q;

  // redirect target, forced to a word boundary
  assign redir_addr = {fetch_addr_n_i[`IF_XLEN-1:if_fetch_pkg::WordOffW],
                       {if_fetch_pkg::WordOffW{1'b0}}};

  ////////////////////////////////////////////////////////////////////
  // response side
  ////////////////////////////////////////////////////////////////////

  // drop answers of an old stream, and anything arriving with a redirect
  assign rsp_keep = instr_rvalid_i & out_q & ~discard_q & ~pc_set_i;
  assign buf_pop  = buf_valid_q & fetch.fetch_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_addr_q <= '0;
      hold_q       <= 1'b0;
      hold_stale_q <= 1'b0;
      out_q        <= 1'b0;
      discard_q    <= 1'b0;
      buf_valid_q  <= 1'b0;
    end else begin
      // stream address, redirect wins over the grant increment
      if (pc_set_i) begin
        fetch_addr_q <= redir_addr;
      end else if (gnt_acc && !hold_stale_q) begin
        fetch_addr_q <= fetch_addr_q + if_fetch_pkg::addr_t'(if_fetch_pkg::WordBytes);
      end

      // held request remembers a redirect seen while waiting
      hold_q       <= instr_req_o & ~instr_gnt_i;
      hold_stale_q <= instr_req_o & ~instr_gnt_i & (hold_stale_q | pc_set_i);

      // outstanding tracking, grant and rvalid never coincide
      if (gnt_acc) begin
        out_q     <= 1'b1;
        discard_q <= hold_stale_q | pc_set_i;
      end else if (instr_rvalid_i) begin
        out_q     <= 1'b0;
        discard_q <= 1'b0;
      end else if (pc_set_i && out_q) begin
        discard_q <= 1'b1;
      end

      // buffer flag, flushed on redirect
      if (pc_set_i) begin
        buf_valid_q <= 1'b0;
      end else if (rsp_keep) begin
        buf_valid_q <= 1'b1;
      end else if (buf_pop) begin
        buf_valid_q <= 1'b0;
      end
    end
  end

  // payload registers
  always_ff @(posedge clk_i) begin
    if (req_new && !instr_gnt_i) begin
      hold_addr_q <= fetch_addr_q;
    end
    if (gnt_acc) begin
      rsp_addr_q <= instr_addr_o;
    end
    if (rsp_keep) begin
      buf_rdata_q <= instr_rdata_i;
      buf_addr_q  <= rsp_addr_q;
      buf_err_q   <= instr_err_i;
    end
  end

  // buffer drives the word channel
  assign fetch.fetch_valid = buf_valid_q;
  assign fetch.fetch_rdata = buf_rdata_q;
  assign fetch.fetch_addr  = buf_addr_q;
  assign fetch.fetch_err   = buf_err_q;

endmodule

/* rtl/if_fetch_addr_mux.sv */
// next fetch address selection
// builds the exception vector, then picks boot, jump, vector or return pc

`timescale 1ns/1ns

`include "if_params.svh"

module if_fetch_addr_mux (
  input  if_ctrl_pkg::pc_sel_e     pc_mux_i,
  input  if_ctrl_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  if_ctrl_pkg::exc_cause_t  exc_cause_i,
  input  if_fetch_pkg::addr_t      boot_addr_i,
  input  if_fetch_pkg::addr_t      branch_target_i,
  input  if_fetch_pkg::addr_t      csr_mepc_i,
  input  if_fetch_pkg::addr_t      csr_depc_i,
  input  if_fetch_pkg::addr_t      csr_mtvec_i,
  output if_fetch_pkg::addr_t      fetch_addr_n_o
);

  if_fetch_pkg::addr_t mtvec_base;
  if_fetch_pkg::addr_t irq_offset;
  if_fetch_pkg::addr_t boot_entry;
  if_fetch_pkg::addr_t exc_pc;

  // vector table base, low bits forced to zero
  assign mtvec_base = {csr_mtvec_i[`IF_XLEN-1:`IF_MTVEC_LSB], {`IF_MTVEC_LSB{1'b0}}};

  // one word per interrupt line
  assign irq_offset = if_fetch_pkg::addr_t'(exc_cause_i.irq_id) << `IF_VEC_SHIFT;

  // boot entry sits at a fixed offset in the aligned boot region
  assign boot_entry = {boot_addr_i[`IF_XLEN-1:`IF_MTVEC_LSB], `IF_BOOT_OFFSET};

  ////////////////////////////////////////////////////////////////////
  // exception vector
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    case (exc_pc_mux_i)
      if_ctrl_pkg::EXC_PC_EXC:     exc_pc = mtvec_base;
      // vectored mode, offset lands inside the cleared low bits
      if_ctrl_pkg::EXC_PC_IRQ:     exc_pc = mtvec_base | irq_offset;
      if_ctrl_pkg::EXC_PC_DBD:     exc_pc = `IF_DM_HALT_ADDR;
      if_ctrl_pkg::EXC_PC_DBG_EXC: exc_pc = `IF_DM_EXC_ADDR;
      default:                     exc_pc = mtvec_base;
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // fetch address
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    case (pc_mux_i)
      if_ctrl_pkg::PC_BOOT: fetch_addr_n_o = boot_entry;
      if_ctrl_pkg::PC_JUMP: fetch_addr_n_o = branch_target_i;
      if_ctrl_pkg::PC_EXC:  fetch_addr_n_o = exc_pc;
      // return from trap handler
      if_ctrl_pkg::PC_ERET: fetch_addr_n_o = csr_mepc_i;
      // return from debug mode
      if_ctrl_pkg::PC_DRET: fetch_addr_n_o = csr_depc_i;
      // unknown select restarts at the boot entry
      default:              fetch_addr_n_o = boot_entry;
    endcase
  end

endmodule

/* rtl/if_fetch_intf.sv */
// fetched word channel
// carries one buffered word from the fetch unit to the IF-ID register

`timescale 1ns/1ns

interface if_fetch_intf;

  // word handshake, transfer when valid and ready are both high
  logic                 fetch_valid;
  logic                 fetch_ready;
  // word payload
  if_fetch_pkg::instr_t fetch_rdata;
  if_fetch_pkg::addr_t  fetch_addr;
  logic                 fetch_err;

  // fetch unit side
  modport src (
    output fetch_valid, fetch_rdata, fetch_addr, fetch_err,
    input  fetch_ready
  );

  // pipeline register side
  modport dst (
    input  fetch_valid, fetch_rdata, fetch_addr, fetch_err,
    output fetch_ready
  );

endinterface

/* rtl/if_fetch_pkg.sv */
// fetch datapath types
// byte address and instruction word

`include "if_params.svh"

package if_fetch_pkg;

  // byte address on the instruction bus
  typedef logic [`IF_XLEN-1:0] addr_t;

  // one fetched instruction word
  typedef logic [`IF_XLEN-1:0] instr_t;

  // size of one word in bytes, used for sequential increment
  localparam int unsigned WordBytes = `IF_XLEN / 8;

  // number of byte offset bits inside a word
  localparam int unsigned WordOffW = $clog2(WordBytes);

endpackage

/* rtl/if_ctrl_pkg.sv */
// fetch control types
// next-pc source select, exception vector select and exception cause

package if_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////
  // pc selection
  ////////////////////////////////////////////////////////////////////

  // source of the next fetch address on a redirect
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // source of the exception vector
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  ////////////////////////////////////////////////////////////////////
  // exception cause
  ////////////////////////////////////////////////////////////////////

  // top bit marks an interrupt, low bits hold the interrupt id
  typedef struct packed {
    logic       irq;
    logic [4:0] irq_id;
  } exc_cause_t;

endpackage

/* rtl/if_params.svh */
// fetch front end parameters
// widths, debug entry points and exception vector layout

`ifndef IF_PARAMS_SVH
`define IF_PARAMS_SVH

// address and instruction word width
`define IF_XLEN 32

// debug module entry points
`define IF_DM_HALT_ADDR 32'h1A110800
`define IF_DM_EXC_ADDR  32'h1A110808

// boot entry inside the 256-byte aligned boot region
`define IF_BOOT_OFFSET 8'h80

// low bits of mtvec and boot address replaced by the mux
`define IF_MTVEC_LSB 8
// interrupt id to vector offset shift
`define IF_VEC_SHIFT 2

`endif
